// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = rv_core_slice_tb
FILELIST  = build.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and pass only on the pass message"
	@echo "  clean  remove obj_dir"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^sim passed$$"

clean:
	rm -rf obj_dir

// ==== build.f ====
src/rv_pkg.sv
src/rv_regfile.sv
src/rv_decode.sv
src/rv_idex_reg.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core_slice.sv
test/rv_core_slice_properties.sv
test/rv_core_slice_tb.sv

// ==== src/rv_core_slice.sv ====
`timescale 1ns/1ps

module rv_core_slice #(
    parameter int NUM_REGS = 32
) (
    input  logic            i_Clock,
    input  logic            i_rst_n,
    input  logic            i_flush,
    input  logic            i_inst_req,
    input  rv_pkg::inst_t   i_inst,
    input  rv_pkg::pc_t     i_pc,
    output logic            o_inst_ack,
    output logic            o_ret_req,
    output rv_pkg::retire_t o_ret,
    input  logic            i_ret_ack
);

    rv_pkg::reg_addr_t rs1_addr, rs2_addr, wr_addr, retire_addr, squash_addr;
    rv_pkg::xlen_t     rs1_data, rs2_data, wr_data;
    rv_pkg::idex_t     dec_idex, ex_idex;
    rv_pkg::exres_t    exres;
    logic              dec_valid, ex_valid, res_valid;
    logic              idex_busy, ex_busy, res_busy;
    logic              wr_en, retire_en, squash_en;

    rv_decode #(.NUM_REGS(NUM_REGS)) u_decode (
        .i_Clock(i_Clock), .i_rst_n(i_rst_n),
        .i_inst_req(i_inst_req), .i_inst(i_inst), .i_pc(i_pc), .o_inst_ack(o_inst_ack),
        .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr),
        .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
        .i_stall(idex_busy),
        .i_retire_en(retire_en), .i_retire_addr(retire_addr),
        .i_squash_en(squash_en), .i_squash_addr(squash_addr),
        .o_idex(dec_idex), .o_idex_valid(dec_valid)
    );

    rv_regfile #(.NUM_REGS(NUM_REGS)) u_regfile (
        .i_Clock(i_Clock), .i_rst_n(i_rst_n),
        .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
        .i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data)
    );

    rv_idex_reg u_idex_reg (
        .i_Clock(i_Clock), .i_rst_n(i_rst_n), .i_flush(i_flush), .i_stall(ex_busy),
        .i_idex(dec_idex), .i_valid(dec_valid),
        .o_idex(ex_idex), .o_valid(ex_valid), .o_busy(idex_busy),
        .o_squash_en(squash_en), .o_squash_addr(squash_addr)
    );

    rv_execute u_execute (
        .i_Clock(i_Clock), .i_rst_n(i_rst_n),
        .i_idex(ex_idex), .i_valid(ex_valid), .i_stall(res_busy),
        .o_exres(exres), .o_valid(res_valid), .o_busy(ex_busy)
    );

    rv_result u_result (
        .i_Clock(i_Clock), .i_rst_n(i_rst_n),
        .i_exres(exres), .i_valid(res_valid), .o_busy(res_busy),
        .o_ret_req(o_ret_req), .o_ret(o_ret), .i_ret_ack(i_ret_ack),
        .o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_data(wr_data),
        .o_retire_en(retire_en), .o_retire_addr(retire_addr)
    );

endmodule

// ==== src/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode #(
    parameter int NUM_REGS = 32
) (
    input  logic              i_Clock,
    input  logic              i_rst_n,
    input  logic              i_inst_req,
    input  rv_pkg::inst_t     i_inst,
    input  rv_pkg::pc_t       i_pc,
    output logic              o_inst_ack,
    output rv_pkg::reg_addr_t o_rs1_addr,
    output rv_pkg::reg_addr_t o_rs2_addr,
    input  rv_pkg::xlen_t     i_rs1_data,
    input  rv_pkg::xlen_t     i_rs2_data,
    input  logic              i_stall,
    input  logic              i_retire_en,
    input  rv_pkg::reg_addr_t i_retire_addr,
    input  logic              i_squash_en,
    input  rv_pkg::reg_addr_t i_squash_addr,
    output rv_pkg::idex_t     o_idex,
    output logic              o_idex_valid
);

    logic [2:0]    pend [NUM_REGS];  // Issued writes not yet retired
    rv_pkg::idex_t dec;
    logic [2:0]    f3;
    logic [6:0]    f7;
    logic          use_rs1, use_rs2, legal, alt, hazard, take;

    assign f3 = i_inst[14:12];
    assign f7 = i_inst[31:25];
    assign alt = (f7 == 7'b0100000);
    assign o_rs1_addr = i_inst[19:15];
    assign o_rs2_addr = i_inst[24:20];

    always_comb begin
        dec = '0;
        dec.pc = i_pc;
        dec.opcode = i_inst[6:0];
        dec.rd = i_inst[11:7];
        dec.op_a = i_rs1_data;
        dec.op_b = i_rs2_data;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        legal = 1'b0;
        case (f3)  // funct3 picks the base operation
            3'd0: dec.alu_op = rv_pkg::ADD;
            3'd1: dec.alu_op = rv_pkg::SLL;
            3'd2: dec.alu_op = rv_pkg::SLT;
            3'd3: dec.alu_op = rv_pkg::SLTU;
            3'd4: dec.alu_op = rv_pkg::XOR;
            3'd5: dec.alu_op = alt ? rv_pkg::SRA : rv_pkg::SRL;
            3'd6: dec.alu_op = rv_pkg::OR;
            default: dec.alu_op = rv_pkg::AND;
        endcase
        case (i_inst[6:0])
            rv_pkg::OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                legal = (f7 == '0) || (alt && (f3 == 3'd0 || f3 == 3'd5));
                if (f3 == 3'd0 && alt) dec.alu_op = rv_pkg::SUB;
            end
            rv_pkg::OPC_OP_IMM: begin
                use_rs1 = 1'b1;
                dec.op_b = {{20{i_inst[31]}}, i_inst[31:20]};  // I-type
                if (f3 == 3'd1) legal = (f7 == '0);
                else if (f3 == 3'd5) legal = (f7 == '0) || alt;
                else legal = 1'b1;
            end
            rv_pkg::OPC_LUI: begin
                dec.op_b = {i_inst[31:12], 12'b0};             // U-type
                dec.alu_op = rv_pkg::PASS_B;
                legal = 1'b1;
            end
            default: legal = 1'b0;
        endcase
        dec.we = legal;
        dec.illegal = !legal;
    end

    // Sources with a write still in flight hold the request
    always_comb begin
        hazard = 1'b0;
        if (use_rs1 && o_rs1_addr != '0 && o_rs1_addr < NUM_REGS && pend[o_rs1_addr] != '0)
            hazard = 1'b1;
        if (use_rs2 && o_rs2_addr != '0 && o_rs2_addr < NUM_REGS && pend[o_rs2_addr] != '0)
            hazard = 1'b1;
    end

    assign take = i_inst_req && !o_inst_ack && !hazard && !i_stall;

    always_ff @(posedge i_Clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_inst_ack <= 1'b0;
            o_idex_valid <= 1'b0;
            o_idex <= '0;
        end else begin
            if (take) o_inst_ack <= 1'b1;
            else if (o_inst_ack && !i_inst_req) o_inst_ack <= 1'b0;  // Four-phase return
            if (!i_stall) o_idex_valid <= take;
            if (take) o_idex <= dec;
        end
    end

    always_ff @(posedge i_Clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                pend[r] <= '0;
            end
        end else begin
            for (int r = 1; r < NUM_REGS; r++) begin  // x0 count stays zero
                pend[r] <= pend[r] + 3'(take && dec.we && dec.rd == r)
                                   - 3'(i_retire_en && i_retire_addr == r)
                                   - 3'(i_squash_en && i_squash_addr == r);
            end
        end
    end

endmodule

// ==== src/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute (
    input  logic           i_Clock,
    input  logic           i_rst_n,
    input  rv_pkg::idex_t  i_idex,
    input  logic           i_valid,
    input  logic           i_stall,
    output rv_pkg::exres_t o_exres,
    output logic           o_valid,
    output logic           o_busy
);

    rv_pkg::xlen_t alu_res;
    rv_pkg::xlen_t a, b;
    logic [4:0]    shamt;

    assign a = i_idex.op_a;
    assign b = i_idex.op_b;
    assign shamt = b[4:0];  // Low 5 bits only

    always_comb begin
        case (i_idex.alu_op)
            rv_pkg::ADD:    alu_res = a + b;
            rv_pkg::SUB:    alu_res = a - b;
            rv_pkg::SLL:    alu_res = a << shamt;
            rv_pkg::SLT:    alu_res = {31'b0, $signed(a) < $signed(b)};
            rv_pkg::SLTU:   alu_res = {31'b0, a < b};
            rv_pkg::XOR:    alu_res = a ^ b;
            rv_pkg::SRL:    alu_res = a >> shamt;
            rv_pkg::SRA:    alu_res = $signed(a) >>> shamt;
            rv_pkg::OR:     alu_res = a | b;
            rv_pkg::AND:    alu_res = a & b;
            rv_pkg::PASS_B: alu_res = b;
            default:        alu_res = '0;
        endcase
    end

    assign o_busy = o_valid && i_stall;

    always_ff @(posedge i_Clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            o_exres <= '0;
        end else if (!o_busy) begin
            o_valid <= i_valid;
            o_exres.pc <= i_idex.pc;
            o_exres.rd <= i_idex.rd;
            o_exres.result <= i_idex.illegal ? '0 : alu_res;  // Illegal items carry zero
            o_exres.we <= i_idex.we;
            o_exres.illegal <= i_idex.illegal;
        end
    end

endmodule

// ==== src/rv_idex_reg.sv ====
`timescale 1ns/1ps

module rv_idex_reg (
    input  logic              i_Clock,
    input  logic              i_rst_n,
    input  logic              i_flush,
    input  logic              i_stall,
    input  rv_pkg::idex_t     i_idex,
    input  logic              i_valid,
    output rv_pkg::idex_t     o_idex,
    output logic              o_valid,
    output logic              o_busy,
    output logic              o_squash_en,
    output rv_pkg::reg_addr_t o_squash_addr
);

    logic load;

    // Free, or handing the current item to execute this cycle
    assign o_busy = o_valid && i_stall;
    assign load = !o_busy;

    // Decode counted this write, so tell it the write is gone
    assign o_squash_en = load && i_valid && i_flush && i_idex.we;
    assign o_squash_addr = i_idex.rd;

    always_ff @(posedge i_Clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            o_idex <= '0;
        end else if (load) begin
            o_valid <= i_valid;
            o_idex <= i_idex;
            if (i_flush) o_idex.we <= 1'b0;  // Squash the write, item still retires
        end
    end

endmodule

// ==== src/rv_pkg.sv ====
package rv_pkg;

    // Widths with a meaning of their own
    typedef logic [31:0] xlen_t;      // Data word
    typedef logic [31:0] pc_t;        // Instruction address
    typedef logic [31:0] inst_t;      // Instruction word
    typedef logic [4:0]  reg_addr_t;  // Register index
    typedef logic [6:0]  opcode_t;    // Major opcode field

    localparam opcode_t OPC_OP     = 7'b0110011;  // Register-register ALU
    localparam opcode_t OPC_OP_IMM = 7'b0010011;  // Register-immediate ALU
    localparam opcode_t OPC_LUI    = 7'b0110111;  // Load upper immediate

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        PASS_B                                    // Operand B straight through, for LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        RS_EMPTY,
        RS_REQ,
        RS_WAIT_DROP
    } result_state_e;

    typedef struct packed {
        pc_t       pc;
        opcode_t   opcode;
        alu_op_e   alu_op;
        xlen_t     op_a;
        xlen_t     op_b;        // Immediate or rs2 value
        reg_addr_t rd;
        logic      we;
        logic      illegal;
    } idex_t;

    typedef struct packed {
        pc_t       pc;
        reg_addr_t rd;
        xlen_t     result;
        logic      we;
        logic      illegal;
    } exres_t;

    // Same layout as exres_t
    typedef struct packed {
        pc_t       pc;
        reg_addr_t rd;
        xlen_t     result;
        logic      we;
        logic      illegal;
    } retire_t;

endpackage

// ==== src/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile #(
    parameter int NUM_REGS = 32
) (
    input  logic              i_Clock,
    input  logic              i_rst_n,
    input  rv_pkg::reg_addr_t i_rs1_addr,
    input  rv_pkg::reg_addr_t i_rs2_addr,
    output rv_pkg::xlen_t     o_rs1_data,
    output rv_pkg::xlen_t     o_rs2_data,
    input  logic              i_wr_en,
    input  rv_pkg::reg_addr_t i_wr_addr,
    input  rv_pkg::xlen_t     i_wr_data
);

    rv_pkg::xlen_t regs [NUM_REGS];

    // Index 0 and indices past the file read as zero
    assign o_rs1_data = (i_rs1_addr != '0 && i_rs1_addr < NUM_REGS) ? regs[i_rs1_addr] : '0;
    assign o_rs2_data = (i_rs2_addr != '0 && i_rs2_addr < NUM_REGS) ? regs[i_rs2_addr] : '0;

    always_ff @(posedge i_Clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (i_wr_en && i_wr_addr != '0 && i_wr_addr < NUM_REGS) begin
            regs[i_wr_addr] <= i_wr_data;  // x0 never written
        end
    end

endmodule

// ==== src/rv_result.sv ====
`timescale 1ns/1ps

module rv_result (
    input  logic              i_Clock,
    input  logic              i_rst_n,
    input  rv_pkg::exres_t    i_exres,
    input  logic              i_valid,
    output logic              o_busy,
    output logic              o_ret_req,
    output rv_pkg::retire_t   o_ret,
    input  logic              i_ret_ack,
    output logic              o_wr_en,
    output rv_pkg::reg_addr_t o_wr_addr,
    output rv_pkg::xlen_t     o_wr_data,
    output logic              o_retire_en,
    output rv_pkg::reg_addr_t o_retire_addr
);

    rv_pkg::result_state_e state;
    logic                  accept, load, ack_seen;

    // Empty, or the previous ack is dropping this cycle
    assign accept = (state == rv_pkg::RS_EMPTY) ||
                    (state == rv_pkg::RS_WAIT_DROP && !i_ret_ack);
    assign load = accept && i_valid;
    assign o_busy = !accept;

    assign o_ret_req = (state == rv_pkg::RS_REQ);
    assign ack_seen = o_ret_req && i_ret_ack;  // First edge with ack high

    assign o_wr_en = ack_seen && o_ret.we;
    assign o_wr_addr = o_ret.rd;
    assign o_wr_data = o_ret.result;
    assign o_retire_en = ack_seen && o_ret.we;
    assign o_retire_addr = o_ret.rd;

    always_ff @(posedge i_Clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= rv_pkg::RS_EMPTY;
            o_ret <= '0;
        end else begin
            if (load) o_ret <= rv_pkg::retire_t'(i_exres);  // Held while req is high
            case (state)
                rv_pkg::RS_EMPTY:
                    if (i_valid) state <= rv_pkg::RS_REQ;
                rv_pkg::RS_REQ:
                    if (i_ret_ack) state <= rv_pkg::RS_WAIT_DROP;
                rv_pkg::RS_WAIT_DROP:
                    if (!i_ret_ack) state <= i_valid ? rv_pkg::RS_REQ : rv_pkg::RS_EMPTY;
                default:
                    state <= rv_pkg::RS_EMPTY;
            endcase
        end
    end

endmodule

// ==== test/rv_core_slice_properties.sv ====
`timescale 1ns/1ps

module rv_core_slice_properties (
    input logic            i_Clock,
    input logic            i_rst_n,
    input logic            i_inst_req,
    input logic            o_inst_ack,
    input logic            o_ret_req,
    input rv_pkg::retire_t o_ret,
    input logic            i_ret_ack
);

    int fail_count = 0;  // Failed assertions so far

    // Retire request waits for the environment
    ret_req_held: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
        (o_ret_req && !i_ret_ack) |=> o_ret_req)
        else begin
            $error("o_ret_req dropped before i_ret_ack was seen");
            fail_count++;
        end

    ret_stable: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
        o_ret_req |=> (!o_ret_req || $stable(o_ret)))
        else begin
            $error("o_ret changed while o_ret_req was high");
            fail_count++;
        end

    // Ack rises only for a pending request
    ack_needs_req: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
        $rose(o_inst_ack) |-> $past(i_inst_req))
        else begin
            $error("o_inst_ack rose without i_inst_req");
            fail_count++;
        end

endmodule

bind rv_core_slice rv_core_slice_properties u_props (
    .i_Clock(i_Clock),
    .i_rst_n(i_rst_n),
    .i_inst_req(i_inst_req),
    .o_inst_ack(o_inst_ack),
    .o_ret_req(o_ret_req),
    .o_ret(o_ret),
    .i_ret_ack(i_ret_ack)
);

// ==== test/rv_core_slice_tb.sv ====
`timescale 1ns/1ps

module rv_core_slice_tb;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_INSTS = 100;        // Upper bound on instructions over all tests
    localparam int CYCLES_PER_INST = 40;
    localparam int WAIT_LIMIT = 200;       // Cycles before a handshake wait gives up

    logic            i_Clock;
    logic            i_rst_n;
    logic            i_flush;
    logic            i_inst_req;
    rv_pkg::inst_t   i_inst;
    rv_pkg::pc_t     i_pc;
    logic            o_inst_ack;
    logic            o_ret_req;
    rv_pkg::retire_t o_ret;
    logic            i_ret_ack;

    int              seed;
    int              n_mismatch = 0;
    int              n_other = 0;
    int              n_sent = 0;
    int              n_retired = 0;
    int              ack_delay_max = 0;    // Collector waits 0 to this many cycles
    string           test_name = "none";
    rv_pkg::pc_t     pc_next = '0;
    rv_pkg::xlen_t   model_regs [32];
    rv_pkg::retire_t exp_q [$];            // Expected records in program order
    string           name_q [$];

    rv_core_slice dut0 (.*);

    always #(CLK_PERIOD / 2) i_Clock = ~i_Clock;

    function automatic rv_pkg::xlen_t rand_word();
        return $random(seed);
    endfunction

    function automatic int pick_reg();
        return 1 + int'($unsigned($random(seed)) % 7);  // x1 to x7
    endfunction

    function automatic rv_pkg::inst_t op_inst(input logic [6:0] f7, input int rs2,
                                              input int rs1, input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), rv_pkg::OPC_OP};
    endfunction

    function automatic rv_pkg::inst_t imm_inst(input logic [11:0] imm, input int rs1,
                                               input logic [2:0] f3, input int rd);
        return {imm, 5'(rs1), f3, 5'(rd), rv_pkg::OPC_OP_IMM};
    endfunction

    function automatic rv_pkg::inst_t lui_inst(input logic [19:0] imm, input int rd);
        return {imm, 5'(rd), rv_pkg::OPC_LUI};
    endfunction

    function automatic string rec_text(input rv_pkg::retire_t r);
        return $sformatf("pc=%h rd=%0d result=%h we=%b illegal=%b",
                         r.pc, r.rd, r.result, r.we, r.illegal);
    endfunction

    // RV32I rules applied in program order to the model register array
    function automatic rv_pkg::retire_t model_step(input rv_pkg::inst_t inst,
                                                   input rv_pkg::pc_t pc, input logic flushed);
        rv_pkg::retire_t rec;
        rv_pkg::xlen_t   a;
        rv_pkg::xlen_t   b;
        logic [4:0]      sh;
        rec = '0;
        rec.pc = pc;
        rec.rd = inst[11:7];
        a = model_regs[inst[19:15]];
        if (inst[6:0] == rv_pkg::OPC_OP) b = model_regs[inst[24:20]];
        else b = {{20{inst[31]}}, inst[31:20]};
        sh = b[4:0];
        if (inst[6:0] == rv_pkg::OPC_LUI) begin
            rec.result = {inst[31:12], 12'h000};
        end else if (inst[6:0] == rv_pkg::OPC_OP || inst[6:0] == rv_pkg::OPC_OP_IMM) begin
            case (inst[14:12])
                3'd0: rec.result = (inst[6:0] == rv_pkg::OPC_OP && inst[30]) ? a - b : a + b;
                3'd1: rec.result = a << sh;
                3'd2: rec.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: rec.result = (a < b) ? 32'd1 : 32'd0;
                3'd4: rec.result = a ^ b;
                3'd5: begin
                    if (inst[30]) rec.result = $signed(a) >>> sh;  // Arithmetic
                    else rec.result = a >> sh;
                end
                3'd6: rec.result = a | b;
                default: rec.result = a & b;
            endcase
        end else begin
            rec.illegal = 1'b1;  // Out of scope opcode
        end
        rec.we = !rec.illegal && !flushed;
        if (rec.we && rec.rd != 0) model_regs[rec.rd] = rec.result;
        return rec;
    endfunction

    task automatic send_inst(input rv_pkg::inst_t inst, input logic flushed);
        int waited;
        exp_q.push_back(model_step(inst, pc_next, flushed));
        name_q.push_back(test_name);
        @(posedge i_Clock);
        i_inst_req <= 1'b1;
        i_inst <= inst;
        i_pc <= pc_next;
        pc_next = pc_next + 4;
        n_sent++;
        waited = 0;
        do begin
            @(negedge i_Clock);
            waited++;
        end while (!o_inst_ack && waited < WAIT_LIMIT);
        assert (o_inst_ack) else begin
            $display("timeout in %s: instruction at pc %h was never acknowledged",
                     test_name, i_pc);
            n_other++;
        end
        @(posedge i_Clock);
        i_inst_req <= 1'b0;
        waited = 0;
        do begin
            @(negedge i_Clock);
            waited++;
        end while (o_inst_ack && waited < WAIT_LIMIT);
        assert (!o_inst_ack) else begin
            $display("timeout in %s: o_inst_ack stayed high after the request dropped",
                     test_name);
            n_other++;
        end
    endtask

    task automatic collect_retires();
        rv_pkg::retire_t exp;
        string           name;
        int              delay;
        int              waited;
        forever begin
            @(negedge i_Clock);
            if (o_ret_req) begin
                assert (exp_q.size() != 0) else begin
                    $display("retirement of pc %h arrived with nothing outstanding", o_ret.pc);
                    n_other++;
                end
                if (exp_q.size() != 0) begin
                    exp = exp_q.pop_front();
                    name = name_q.pop_front();
                    assert (o_ret === exp) else begin
                        $display("mismatch in %s: expected %s, actual %s",
                                 name, rec_text(exp), rec_text(o_ret));
                        n_mismatch++;
                    end
                end
                n_retired++;
                delay = int'($unsigned($random(seed)) % (ack_delay_max + 1));
                repeat (delay) @(posedge i_Clock);
                @(posedge i_Clock);
                i_ret_ack <= 1'b1;
                waited = 0;
                do begin
                    @(negedge i_Clock);
                    waited++;
                end while (o_ret_req && waited < WAIT_LIMIT);
                assert (!o_ret_req) else begin
                    $display("o_ret_req stayed high after i_ret_ack was raised");
                    n_other++;
                end
                @(posedge i_Clock);
                i_ret_ack <= 1'b0;
            end
        end
    endtask

    // Returns once every sent instruction has reached the retire port
    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT * 4) begin
            @(negedge i_Clock);
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            $display("%0d instructions in %s never retired", exp_q.size(), test_name);
            n_other++;
        end
        repeat (4) @(posedge i_Clock);
    endtask

    task automatic load_reg(input int r);
        send_inst(lui_inst(20'(rand_word()), r), 1'b0);
        send_inst(imm_inst(12'(rand_word()), r, 3'd0, r), 1'b0);  // Sign-extended low bits
    endtask

    task automatic alu_ops_test();
        logic [11:0] imm;
        test_name = "alu_ops";
        for (int r = 1; r < 8; r++) begin
            load_reg(r);
        end
        repeat (2) begin
            for (int f = 0; f < 8; f++) begin
                send_inst(op_inst(7'h00, pick_reg(), pick_reg(), 3'(f), pick_reg()), 1'b0);
            end
            send_inst(op_inst(7'h20, pick_reg(), pick_reg(), 3'd0, pick_reg()), 1'b0);  // SUB
            send_inst(op_inst(7'h20, pick_reg(), pick_reg(), 3'd5, pick_reg()), 1'b0);  // SRA
            for (int f = 0; f < 8; f++) begin
                imm = 12'(rand_word());
                if (f == 1 || f == 5) imm[11:5] = 7'h00;  // Shift amount only
                send_inst(imm_inst(imm, pick_reg(), 3'(f), pick_reg()), 1'b0);
            end
            imm = {7'h20, 5'(rand_word())};                // SRAI
            send_inst(imm_inst(imm, pick_reg(), 3'd5, pick_reg()), 1'b0);
            send_inst(lui_inst(20'(rand_word()), pick_reg()), 1'b0);
        end
    endtask

    task automatic x0_test();
        test_name = "x0_write";
        send_inst(imm_inst(12'h123, 1, 3'd0, 0), 1'b0);  // Value retires but x0 stays zero
        send_inst(op_inst(7'h00, 0, 0, 3'd0, 3), 1'b0);
        send_inst(imm_inst(12'h055, 0, 3'd6, 4), 1'b0);
    endtask

    task automatic dep_chain_test();
        test_name = "dep_chain";
        for (int i = 0; i < 8; i++) begin
            send_inst(imm_inst(12'(rand_word()), 5, 3'd0, 5), 1'b0);  // Each reads the last
        end
        send_inst(op_inst(7'h00, 5, 5, 3'd0, 6), 1'b0);
    endtask

    task automatic slow_ack_test();
        test_name = "slow_ack";
        ack_delay_max = 10;
        for (int i = 0; i < 20; i++) begin
            if (i % 2 == 1)
                send_inst(op_inst(7'h00, pick_reg(), pick_reg(), 3'(rand_word()), pick_reg()),
                          1'b0);
            else
                send_inst(imm_inst(12'(rand_word()), pick_reg(), 3'd0, pick_reg()), 1'b0);
        end
        drain();
        ack_delay_max = 0;
    endtask

    task automatic flush_test();
        test_name = "flush";
        send_inst(imm_inst(12'h2a5, 0, 3'd0, 7), 1'b0);
        drain();                                          // Pipeline empty before the flush
        @(posedge i_Clock);
        i_flush <= 1'b1;
        send_inst(imm_inst(12'h7ff, 7, 3'd0, 7), 1'b1);
        drain();
        @(posedge i_Clock);
        i_flush <= 1'b0;
        send_inst(imm_inst(12'h000, 7, 3'd0, 8), 1'b0);  // Reads the old x7
    endtask

    task automatic illegal_op_test();
        test_name = "illegal_op";
        send_inst({20'(rand_word()), 5'd2, 7'b0000011}, 1'b0);  // LOAD
        send_inst({20'(rand_word()), 5'd2, 7'b1100011}, 1'b0);  // BRANCH
        send_inst(imm_inst(12'h000, 2, 3'd0, 9), 1'b0);         // x2 untouched
    endtask

    initial begin
        seed = 32'h3571;
        i_Clock = 1'b0;
        i_rst_n = 1'b0;
        i_flush = 1'b0;
        i_inst_req = 1'b0;
        i_inst = '0;
        i_pc = '0;
        i_ret_ack = 1'b0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (RESET_CYCLES) @(posedge i_Clock);
        i_rst_n <= 1'b1;
        fork
            collect_retires();
        join_none
        alu_ops_test();
        x0_test();
        dep_chain_test();
        slow_ack_test();
        flush_test();
        illegal_op_test();
        drain();
        n_other = n_other + dut0.u_props.fail_count;  // Handshake assertion failures
        $display("errors: %0d mismatches, %0d other failures, %0d of %0d instructions retired",
                 n_mismatch, n_other, n_retired, n_sent);
        if (n_mismatch == 0 && n_other == 0 && n_retired == n_sent)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + MAX_INSTS * CYCLES_PER_INST + 1000) @(posedge i_Clock);
        $display("watchdog expired in %s before the tests finished", test_name);
        $display("errors: %0d mismatches, %0d other failures, %0d of %0d instructions retired",
                 n_mismatch, n_other + dut0.u_props.fail_count + 1, n_retired, n_sent);
        $display("sim failed");
        $finish;
    end

endmodule
